//--- Makefile
# Verilator build and run for the eviction read path testbench

VERILATOR ?= verilator
TOP       ?= evict_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := hw/ev_consts.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "^TEST OK$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- hw/array_rd_ctl.sv
// Array read control for the write-back and DMA arrays
// Registers read enables and wordlines to r1, carries enables to r2,
// captures the selected array line at r3 and delays the DMA enable to r3

`timescale 1ns/1ps

module array_rd_ctl
   import ev_pkg::*;
(
   input  logic    rclk,
   input  logic    arst_n,
   input  logic    wbrd_en_r0,
   input  wb_wl_t  wbrd_wl_r0,
   input  logic    dma_rden_r0,
   input  dma_wl_t dma_rdwl_r0,
   input  line_t   wb_array_dout,
   input  line_t   dma_array_dout,
   output logic    wbrd_en_r1,
   output wb_wl_t  wbrd_wl_r1,
   output logic    dma_rden_r1,
   output dma_wl_t dma_rdwl_r1,
   output line_t   line_r3,
   output logic    dma_rden_r3
);

   logic  wbrd_en_r2;
   logic  dma_rden_r2;
   logic  line_load;
   line_t line_mux;

   //////////////////////////////////////////////////////////////////////
   // Read controls to the arrays and their r2/r3 copies
   //////////////////////////////////////////////////////////////////////
   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         wbrd_en_r1  <= 1'b0;
         wbrd_wl_r1  <= '0;
         dma_rden_r1 <= 1'b0;
         dma_rdwl_r1 <= '0;
         wbrd_en_r2  <= 1'b0;
         dma_rden_r2 <= 1'b0;
         dma_rden_r3 <= 1'b0;
      end else begin
         wbrd_en_r1  <= wbrd_en_r0;
         wbrd_wl_r1  <= wbrd_wl_r0;
         dma_rden_r1 <= dma_rden_r0;
         dma_rdwl_r1 <= dma_rdwl_r0;
         wbrd_en_r2  <= wbrd_en_r1;
         dma_rden_r2 <= dma_rden_r1;
         dma_rden_r3 <= dma_rden_r2;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Line capture
   //////////////////////////////////////////////////////////////////////

   // Write-back read wins when both arrays are read in the same cycle
   assign line_load = wbrd_en_r2 | dma_rden_r2;
   assign line_mux  = wbrd_en_r2 ? wb_array_dout : dma_array_dout;

   always_ff @(posedge rclk) begin
      if (line_load) begin
         line_r3 <= line_mux;
      end
   end

endmodule

//--- hw/dword_select.sv
// Eviction control and dword selection
// Delays the evict strobe and dword index to r3, picks one dword of the
// captured line, tracks the DMA error qualifier and registers the r4 item

`timescale 1ns/1ps
`include "ev_consts.svh"

module dword_select
   import ev_pkg::*;
(
   input  logic       rclk,
   input  logic       arst_n,
   input  logic       evict_en_r0,
   input  dword_idx_t ev_dword_r0,
   input  line_t      line_r3,
   input  logic       dma_rden_r3,
   output ev_r4_t     ev_r4
);

   logic       evict_en_r1;
   logic       evict_en_r2;
   logic       evict_en_r3;
   dword_idx_t ev_dword_r1;
   dword_idx_t ev_dword_r2;
   dword_idx_t ev_dword_r3;
   dword_idx_t seg_idx;
   dword_t     dword_r3;
   logic       error_qual;
   logic       error_qual_in;
   logic       valid_r4;
   dword_t     dword_r4;

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         evict_en_r1 <= 1'b0;
         evict_en_r2 <= 1'b0;
         evict_en_r3 <= 1'b0;
      end else begin
         evict_en_r1 <= evict_en_r0;
         evict_en_r2 <= evict_en_r1;
         evict_en_r3 <= evict_en_r2;
      end
   end

   always_ff @(posedge rclk) begin
      ev_dword_r1 <= ev_dword_r0;
      ev_dword_r2 <= ev_dword_r1;
      ev_dword_r3 <= ev_dword_r2;
   end

   // Dword 0 lives in the top segment of the line
   assign seg_idx  = dword_idx_t'(`EV_DWORDS - 1) - ev_dword_r3;
   assign dword_r3 = line_r3[seg_idx * `EV_DWORD_W +: `EV_DWORD_W];

   //////////////////////////////////////////////////////////////////////
   // Error qualifier
   //////////////////////////////////////////////////////////////////////

   // A DMA read arms the qualifier and it stays armed across back to back
   // evictions, so the qualifier register itself is the r4 suppress bit
   assign error_qual_in = dma_rden_r3 | (error_qual & evict_en_r3);

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         error_qual <= 1'b0;
         valid_r4   <= 1'b0;
      end else begin
         error_qual <= error_qual_in;
         valid_r4   <= evict_en_r3;
      end
   end

   always_ff @(posedge rclk) begin
      if (evict_en_r3) begin
         dword_r4 <= dword_r3;
      end
   end

   assign ev_r4.valid    = valid_r4;
   assign ev_r4.suppress = error_qual;
   assign ev_r4.dword    = dword_r4;

endmodule

//--- hw/ev_consts.svh
// Width and count macros for the eviction read path
// Line, dword and ECC word geometry, DRAM data width and wordline widths

`ifndef EV_CONSTS_SVH
`define EV_CONSTS_SVH

// Array line and its dword split
`define EV_LINE_W    624
`define EV_DWORDS    8
`define EV_DWORD_W   78

// One SECDED word is 32 data bits over 7 check bits
`define EV_ECCW_W    39
`define EV_DATA_W    32
`define EV_CHK_W     7

`define EV_OUT_W     64

// Array wordline widths
`define EV_WB_WL_W   3
`define EV_DMA_WL_W  2

`endif

//--- hw/ev_pkg.sv
// Shared types for the eviction read path
// Vector typedefs for lines, dwords, ECC words and wordlines
// Packed structs handed from r4 to the ECC stage and from r5 to the ports

`include "ev_consts.svh"

package ev_pkg;

   typedef logic [`EV_LINE_W-1:0]   line_t;
   typedef logic [`EV_DWORD_W-1:0]  dword_t;
   typedef logic [`EV_ECCW_W-1:0]   eccword_t;
   typedef logic [`EV_DATA_W-1:0]   data32_t;
   typedef logic [`EV_OUT_W-1:0]    dram_data_t;
   typedef logic [$clog2(`EV_DWORDS)-1:0] dword_idx_t;
   typedef logic [`EV_WB_WL_W-1:0]  wb_wl_t;
   typedef logic [`EV_DMA_WL_W-1:0] dma_wl_t;

   // Selected dword on its way into the ECC check
   typedef struct packed {
      logic   valid;
      logic   suppress;
      dword_t dword;
   } ev_r4_t;

   // Registered eviction result driven to DRAM and the tag side
   typedef struct packed {
      dram_data_t data;
      logic       valid;
      logic       mecc;
      logic       uerr;
      logic       cerr;
   } ev_out_t;

endpackage

//--- hw/evict_ecc_stage.sv
// ECC stage of the eviction path
// Checks both words of the r4 dword, builds the qualified and unqualified
// error flags and registers data, valid and flags to r5

`timescale 1ns/1ps
`include "ev_consts.svh"

module evict_ecc_stage
   import ev_pkg::*;
(
   input  logic    rclk,
   input  logic    arst_n,
   input  ev_r4_t  ev_r4,
   output ev_out_t ev_out
);

   data32_t    data_lo;
   data32_t    data_hi;
   logic       corr_lo;
   logic       corr_hi;
   logic       uncorr_lo;
   logic       uncorr_hi;
   logic       mecc_r4;
   logic       uerr_r4;
   logic       cerr_r4;
   dram_data_t data_r5;
   logic       valid_r5;
   logic       mecc_r5;
   logic       uerr_r5;
   logic       cerr_r5;

   // Word 0 sits in the low half of the dword and gives output bits 31:0
   secded39_check u_check_lo (
      .word       (ev_r4.dword[`EV_ECCW_W-1:0]),
      .data       (data_lo),
      .corr_err   (corr_lo),
      .uncorr_err (uncorr_lo)
   );

   secded39_check u_check_hi (
      .word       (ev_r4.dword[`EV_DWORD_W-1:`EV_ECCW_W]),
      .data       (data_hi),
      .corr_err   (corr_hi),
      .uncorr_err (uncorr_hi)
   );

   // mecc goes to DRAM whatever the qualifier says
   assign mecc_r4 = ev_r4.valid & (uncorr_lo | uncorr_hi);
   assign uerr_r4 = ev_r4.valid & ~ev_r4.suppress & (uncorr_lo | uncorr_hi);
   assign cerr_r4 = ev_r4.valid & ~ev_r4.suppress & (corr_lo | corr_hi);

   always_ff @(posedge rclk or negedge arst_n) begin
      if (!arst_n) begin
         valid_r5 <= 1'b0;
         mecc_r5  <= 1'b0;
         uerr_r5  <= 1'b0;
         cerr_r5  <= 1'b0;
      end else begin
         valid_r5 <= ev_r4.valid;
         mecc_r5  <= mecc_r4;
         uerr_r5  <= uerr_r4;
         cerr_r5  <= cerr_r4;
      end
   end

   always_ff @(posedge rclk) begin
      data_r5 <= {data_hi, data_lo};
   end

   assign ev_out.data  = data_r5;
   assign ev_out.valid = valid_r5;
   assign ev_out.mecc  = mecc_r5;
   assign ev_out.uerr  = uerr_r5;
   assign ev_out.cerr  = cerr_r5;

endmodule

//--- hw/evict_top.sv
// Eviction read path top level
// Array read control, dword select and ECC stage, with the r5 result
// unpacked onto the DRAM and error ports

`timescale 1ns/1ps

module evict_top
   import ev_pkg::*;
(
   input  logic       rclk,
   input  logic       arst_n,
   input  logic       wbrd_en_r0,
   input  wb_wl_t     wbrd_wl_r0,
   input  logic       dma_rden_r0,
   input  dma_wl_t    dma_rdwl_r0,
   input  logic       evict_en_r0,
   input  dword_idx_t ev_dword_r0,
   input  line_t      wb_array_dout,
   input  line_t      dma_array_dout,
   output logic       wbrd_en_r1,
   output wb_wl_t     wbrd_wl_r1,
   output logic       dma_rden_r1,
   output dma_wl_t    dma_rdwl_r1,
   output dram_data_t dram_wr_data_r5,
   output logic       dram_data_vld_r5,
   output logic       dram_data_mecc_r5,
   output logic       ev_uerr_r5,
   output logic       ev_cerr_r5
);

   line_t   line_r3;
   logic    dma_rden_r3;
   ev_r4_t  ev_r4;
   ev_out_t ev_out;

   array_rd_ctl u_array_rd_ctl (
      .rclk           (rclk),
      .arst_n         (arst_n),
      .wbrd_en_r0     (wbrd_en_r0),
      .wbrd_wl_r0     (wbrd_wl_r0),
      .dma_rden_r0    (dma_rden_r0),
      .dma_rdwl_r0    (dma_rdwl_r0),
      .wb_array_dout  (wb_array_dout),
      .dma_array_dout (dma_array_dout),
      .wbrd_en_r1     (wbrd_en_r1),
      .wbrd_wl_r1     (wbrd_wl_r1),
      .dma_rden_r1    (dma_rden_r1),
      .dma_rdwl_r1    (dma_rdwl_r1),
      .line_r3        (line_r3),
      .dma_rden_r3    (dma_rden_r3)
   );

   dword_select u_dword_select (
      .rclk        (rclk),
      .arst_n      (arst_n),
      .evict_en_r0 (evict_en_r0),
      .ev_dword_r0 (ev_dword_r0),
      .line_r3     (line_r3),
      .dma_rden_r3 (dma_rden_r3),
      .ev_r4       (ev_r4)
   );

   evict_ecc_stage u_evict_ecc_stage (
      .rclk   (rclk),
      .arst_n (arst_n),
      .ev_r4  (ev_r4),
      .ev_out (ev_out)
   );

   assign dram_wr_data_r5   = ev_out.data;
   assign dram_data_vld_r5  = ev_out.valid;
   assign dram_data_mecc_r5 = ev_out.mecc;
   assign ev_uerr_r5        = ev_out.uerr;
   assign ev_cerr_r5        = ev_out.cerr;

endmodule

//--- hw/secded39_check.sv
// SECDED check of one 39-bit word
// Syndrome and overall parity, single data bit correction and the
// correctable and uncorrectable flags

`timescale 1ns/1ps
`include "ev_consts.svh"

module secded39_check
   import ev_pkg::*;
(
   input  eccword_t word,
   output data32_t  data,
   output logic     corr_err,
   output logic     uncorr_err
);

   localparam int SYN_W = `EV_CHK_W - 1;

   logic [SYN_W-1:0] syndrome;
   logic             parity_err;
   data32_t          raw_data;

   // Hamming position of data bit idx, skipping the power of two slots
   function automatic logic [SYN_W-1:0] data_pos(input int idx);
      int               cnt;
      logic [SYN_W-1:0] pos;
      cnt = 0;
      pos = '0;
      for (int p = 3; p < `EV_ECCW_W; p++) begin
         if ((p & (p - 1)) != 0) begin
            if (cnt == idx) pos = SYN_W'(p);
            cnt++;
         end
      end
      return pos;
   endfunction

   assign raw_data   = word[`EV_ECCW_W-1:`EV_CHK_W];
   // Check bit 6 covers the other 38 bits, so the full word has even parity
   assign parity_err = ^word;

   always_comb begin
      syndrome = '0;
      for (int c = 0; c < SYN_W; c++) begin
         if (word[c]) syndrome ^= SYN_W'(1 << c);
      end
      for (int i = 0; i < `EV_DATA_W; i++) begin
         if (raw_data[i]) syndrome ^= data_pos(i);
      end
   end

   always_comb begin
      for (int i = 0; i < `EV_DATA_W; i++) begin
         data[i] = raw_data[i] ^ (parity_err && (syndrome == data_pos(i)));
      end
   end

   assign corr_err   = parity_err;
   assign uncorr_err = (syndrome != '0) && !parity_err;

endmodule

//--- project.f
+incdir+hw
hw/ev_pkg.sv
hw/secded39_check.sv
hw/array_rd_ctl.sv
hw/dword_select.sv
hw/evict_ecc_stage.sv
hw/evict_top.sv
verification/evict_tb.sv

//--- verification/evict_tb.sv
// Testbench for the eviction read path
// SECDED line builder, reference model of the r5 result, per-cycle
// scoreboard of array controls and eviction outputs, and the final report

`timescale 1ns/1ps
`include "ev_consts.svh"

module evict_tb;
   import ev_pkg::*;

   logic       rclk = 1'b0;
   logic       arst_n;
   logic       wbrd_en_r0;
   wb_wl_t     wbrd_wl_r0;
   logic       dma_rden_r0;
   dma_wl_t    dma_rdwl_r0;
   logic       evict_en_r0;
   dword_idx_t ev_dword_r0;
   line_t      wb_array_dout;
   line_t      dma_array_dout;
   logic       wbrd_en_r1;
   wb_wl_t     wbrd_wl_r1;
   logic       dma_rden_r1;
   dma_wl_t    dma_rdwl_r1;
   dram_data_t dram_wr_data_r5;
   logic       dram_data_vld_r5;
   logic       dram_data_mecc_r5;
   logic       ev_uerr_r5;
   logic       ev_cerr_r5;

   // Model state, array data delay line and expected results
   line_t      wb_pipe [0:1];
   line_t      dma_pipe [0:1];
   line_t      ref_clean;
   line_t      ref_flips;
   logic       qual;
   logic       exp_wb_en;
   wb_wl_t     exp_wb_wl;
   logic       exp_dma_en;
   dma_wl_t    exp_dma_wl;
   ev_out_t    exp_q [$];
   int         due_q [$];
   int         cyc;
   int         checks;
   int         errors;

   evict_top DUT (.*);

   initial begin
      forever #4 rclk = ~rclk;
   end

   always @(posedge rclk) cyc++;

   // SECDED encode with data at word bits 38:7, Hamming check bits at 5:0 and parity at bit 6
   function automatic eccword_t encode(input data32_t d);
      eccword_t   w;
      logic [5:0] syn;
      int         j;
      w = '0;
      w[`EV_ECCW_W-1:`EV_CHK_W] = d;
      syn = '0;
      j = 0;
      for (int pos = 1; pos < `EV_ECCW_W; pos++) begin
         if ((pos & (pos - 1)) != 0) begin
            if (d[j]) syn ^= pos[5:0];
            j++;
         end
      end
      w[5:0] = syn;
      w[6] = ^{w[`EV_ECCW_W-1:`EV_CHK_W], w[5:0]};
      return w;
   endfunction

   function automatic line_t make_line();
      line_t l;
      for (int s = 0; s < 2 * `EV_DWORDS; s++) begin
         l[s*`EV_ECCW_W +: `EV_ECCW_W] = encode($urandom);
      end
      return l;
   endfunction

   // Dword d lives in segment 7-d
   function automatic line_t flip_at(input dword_idx_t idx, input int word, input int bit_pos);
      line_t m;
      int    seg;
      m = '0;
      seg = `EV_DWORDS - 1 - int'(idx);
      m[seg*`EV_DWORD_W + word*`EV_ECCW_W + bit_pos] = 1'b1;
      return m;
   endfunction

   // One flip corrects with cerr, two flips leave raw data with uerr and mecc
   function automatic ev_out_t ref_out(input line_t clean, input line_t flips,
                                       input dword_idx_t idx, input logic supp);
      ev_out_t  r;
      dword_t   cw;
      dword_t   fm;
      eccword_t w;
      eccword_t m;
      eccword_t x;
      int       n;
      int       seg;
      logic     any_c;
      logic     any_u;
      seg = `EV_DWORDS - 1 - int'(idx);
      cw = clean[seg*`EV_DWORD_W +: `EV_DWORD_W];
      fm = flips[seg*`EV_DWORD_W +: `EV_DWORD_W];
      any_c = 1'b0;
      any_u = 1'b0;
      for (int k = 0; k < 2; k++) begin
         w = cw[k*`EV_ECCW_W +: `EV_ECCW_W];
         m = fm[k*`EV_ECCW_W +: `EV_ECCW_W];
         x = w ^ m;
         n = $countones(m);
         r.data[k*`EV_DATA_W +: `EV_DATA_W] = (n == 2) ? x[`EV_ECCW_W-1:`EV_CHK_W]
                                                       : w[`EV_ECCW_W-1:`EV_CHK_W];
         if (n == 1) any_c = 1'b1;
         if (n == 2) any_u = 1'b1;
      end
      r.valid = 1'b1;
      r.mecc  = any_u;
      r.uerr  = any_u & ~supp;
      r.cerr  = any_c & ~supp;
      return r;
   endfunction

   task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   // One clock cycle of stimulus; array data follows its read enable by two cycles
   task automatic step(input logic wb_en, input logic dma_en, input logic ev_en,
                       input dword_idx_t idx, input line_t flips);
      line_t wb_clean;
      line_t dma_clean;
      logic  q_in;
      @(posedge rclk);
      #1;
      exp_wb_en  = wbrd_en_r0;
      exp_wb_wl  = wbrd_wl_r0;
      exp_dma_en = dma_rden_r0;
      exp_dma_wl = dma_rdwl_r0;
      wb_clean  = make_line();
      dma_clean = make_line();
      wb_array_dout  = wb_pipe[1];
      dma_array_dout = dma_pipe[1];
      wb_pipe[1]  = wb_pipe[0];
      dma_pipe[1] = dma_pipe[0];
      wb_pipe[0]  = wb_en ? (wb_clean ^ flips) : wb_clean;
      dma_pipe[0] = dma_en ? (dma_clean ^ flips) : dma_clean;
      wbrd_en_r0  = wb_en;
      wbrd_wl_r0  = wb_wl_t'($urandom);
      dma_rden_r0 = dma_en;
      dma_rdwl_r0 = dma_wl_t'($urandom);
      evict_en_r0 = ev_en;
      ev_dword_r0 = idx;
      if (wb_en) begin
         ref_clean = wb_clean;
         ref_flips = flips;
      end else if (dma_en) begin
         ref_clean = dma_clean;
         ref_flips = flips;
      end
      q_in = dma_en | (qual & ev_en);
      qual = q_in;
      if (ev_en) begin
         exp_q.push_back(ref_out(ref_clean, ref_flips, idx, q_in));
         due_q.push_back(cyc + 5);
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while (due_q.size() > 0 && n < 20) begin
         step(1'b0, 1'b0, 1'b0, '0, '0);
         n++;
      end
      if (due_q.size() > 0) begin
         errors++;
         $display("Timeout: eviction results were still pending after 20 idle cycles");
      end
   endtask

   always @(negedge rclk) begin : scoreboard
      ev_out_t e;
      compare("wbrd_en_r1", 64'(wbrd_en_r1), 64'(exp_wb_en));
      compare("wbrd_wl_r1", 64'(wbrd_wl_r1), 64'(exp_wb_wl));
      compare("dma_rden_r1", 64'(dma_rden_r1), 64'(exp_dma_en));
      compare("dma_rdwl_r1", 64'(dma_rdwl_r1), 64'(exp_dma_wl));
      e = '0;
      if (due_q.size() > 0 && due_q[0] == cyc) begin
         e = exp_q.pop_front();
         void'(due_q.pop_front());
         compare("dram_wr_data_r5", dram_wr_data_r5, e.data);
      end
      compare("dram_data_vld_r5", 64'(dram_data_vld_r5), 64'(e.valid));
      compare("dram_data_mecc_r5", 64'(dram_data_mecc_r5), 64'(e.mecc));
      compare("ev_uerr_r5", 64'(ev_uerr_r5), 64'(e.uerr));
      compare("ev_cerr_r5", 64'(ev_cerr_r5), 64'(e.cerr));
   end

   initial begin
      int    b1;
      int    b2;
      line_t mask;
      void'($urandom(28821));
      {cyc, checks, errors} = '0;
      {wbrd_en_r0, wbrd_wl_r0, dma_rden_r0, dma_rdwl_r0, evict_en_r0, ev_dword_r0} = '0;
      {exp_wb_en, exp_wb_wl, exp_dma_en, exp_dma_wl, qual} = '0;
      wb_array_dout  = '0;
      dma_array_dout = '0;
      wb_pipe  = '{default: '0};
      dma_pipe = '{default: '0};
      ref_clean = '0;
      ref_flips = '0;
      arst_n = 1'b0;
      repeat (8) @(posedge rclk);
      #1 arst_n = 1'b1;
      repeat (4) step(1'b0, 1'b0, 1'b0, '0, '0);

      ////////////////////////////////////////////////////////////////////
      // Clean write-back evictions, one line and then a new line per cycle
      ////////////////////////////////////////////////////////////////////
      for (int i = 0; i < 8; i++) step(i == 0, 1'b0, 1'b1, dword_idx_t'(i), '0);
      for (int i = 0; i < 8; i++) step(1'b1, 1'b0, 1'b1, dword_idx_t'(7 - i), '0);
      drain();

      // Single flips in either word, then the overall parity bit alone
      for (int i = 0; i < 8; i++) begin
         step(1'b1, 1'b0, 1'b1, dword_idx_t'(i), flip_at(dword_idx_t'(i), i % 2,
              int'($urandom % 39)));
      end
      step(1'b1, 1'b0, 1'b1, 3'd2, flip_at(3'd2, 0, 6));
      step(1'b1, 1'b0, 1'b1, 3'd5, flip_at(3'd5, 1, 6));
      drain();

      // Double flips within one word
      for (int i = 0; i < 6; i++) begin
         b1 = int'($urandom % 39);
         b2 = (b1 + 1 + int'($urandom % 38)) % 39;
         mask = flip_at(dword_idx_t'(i), i % 2, b1) | flip_at(dword_idx_t'(i), i % 2, b2);
         step(1'b1, 1'b0, 1'b1, dword_idx_t'(i), mask);
      end
      drain();

      ////////////////////////////////////////////////////////////////////
      // DMA-sourced line: contiguous evictions masked, reporting back after a gap
      ////////////////////////////////////////////////////////////////////
      mask = flip_at(3'd0, 0, 20) | flip_at(3'd1, 1, 3) | flip_at(3'd1, 1, 30) |
             flip_at(3'd2, 1, 11);
      step(1'b0, 1'b1, 1'b1, 3'd0, mask);
      step(1'b0, 1'b0, 1'b1, 3'd1, '0);
      step(1'b0, 1'b0, 1'b1, 3'd2, '0);
      step(1'b0, 1'b0, 1'b0, '0, '0);
      step(1'b0, 1'b0, 1'b1, 3'd0, '0);
      step(1'b0, 1'b0, 1'b1, 3'd1, '0);
      step(1'b0, 1'b1, 1'b0, '0, flip_at(3'd4, 0, 9) | flip_at(3'd4, 0, 17));
      step(1'b0, 1'b0, 1'b1, 3'd4, '0);
      drain();

      // Mixed random traffic
      for (int i = 0; i < 40; i++) begin
         step(($urandom % 2) == 1, ($urandom % 4) == 0, ($urandom % 3) != 0,
              dword_idx_t'($urandom), ($urandom % 2) == 1 ?
              flip_at(dword_idx_t'($urandom), int'($urandom % 2), int'($urandom % 39)) : '0);
      end
      drain();

      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule
